/* Makefile */
TOP := coh_cache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module coh_cache_top -f coh_cache_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f coh_cache_top.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* coh_cache_top.f */
+incdir+tests
hw/cache_geom_pkg.sv
hw/cache_msg_pkg.sv
hw/line_store.sv
hw/req_decode.sv
hw/miss_control.sv
hw/resp_update.sv
hw/coh_cache_top.sv
tests/coh_cache_tb.sv

/* hw/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

  // --------------------
  // array geometry
  // --------------------
  localparam int NUM_WAYS = 4;
  localparam int NUM_SETS = 16;
  localparam int IDX_W    = 4;
  localparam int TAG_W    = 12;
  localparam int LINE_W   = 32;
  localparam int ADDR_W   = TAG_W + IDX_W;
  localparam int STATE_W  = 3;

  typedef logic [1:0] way_t;

  // tree bits, [2] picks the half, [1] ways 0/1, [0] ways 2/3
  typedef logic [2:0] plru_t;

  // block address, flat downstream and split for lookup
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
    } split;
  } blk_addr_u;

  // one stored line, state | tag | data
  typedef struct packed {
    logic [STATE_W-1:0] state;
    logic [TAG_W-1:0]   tag;
    logic [LINE_W-1:0]  data;
  } line_entry_t;

endpackage

`default_nettype wire

/* hw/cache_msg_pkg.sv */
`default_nettype none

package cache_msg_pkg;

  // --------------------
  // opcodes and states
  // --------------------
  typedef enum logic [1:0] {RD = 2'd0, WR = 2'd1, RFO = 2'd2} core_op_e;

  typedef enum logic [2:0] {
    INVALID   = 3'd0,
    SHARED    = 3'd1,
    EXCLUSIVE = 3'd2,
    MODIFIED  = 3'd3,
    MIGRATED  = 3'd4
  } coh_state_e;

  typedef enum logic [1:0] {DRD = 2'd0, DRFO = 2'd1, DINV = 2'd2} down_op_e;

  // fill code from downstream, ACK carries no data
  typedef enum logic [1:0] {SNOOP = 2'd0, FETCH = 2'd1, ACK = 2'd2} fill_rsp_e;

  // --------------------
  // channel payloads
  // --------------------
  typedef struct packed {
    core_op_e                          op;
    cache_geom_pkg::blk_addr_u         addr;
    logic [cache_geom_pkg::LINE_W-1:0] data;
  } core_req_t;

  typedef struct packed {
    logic [cache_geom_pkg::LINE_W-1:0] data;
  } core_rsp_t;

  typedef struct packed {
    down_op_e                  op;
    cache_geom_pkg::blk_addr_u addr;
  } down_req_t;

  typedef struct packed {
    fill_rsp_e                         rsp;
    logic [cache_geom_pkg::LINE_W-1:0] data;
  } down_rsp_t;

  // result of the tag compare on the selected way
  typedef struct packed {
    logic                              hit;
    cache_geom_pkg::way_t              way;
    logic [cache_geom_pkg::IDX_W-1:0]  idx;
    coh_state_e                        state;
    logic [cache_geom_pkg::LINE_W-1:0] data;
  } lookup_t;

  typedef struct packed {
    logic                             en;
    logic [cache_geom_pkg::IDX_W-1:0] idx;
    cache_geom_pkg::way_t             way;
    cache_geom_pkg::line_entry_t      entry;
    logic                             tag_wr;
  } line_wr_t;

endpackage

`default_nettype wire

/* hw/coh_cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module coh_cache_top
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      core_req_valid,
  output logic      core_req_ready,
  input  core_req_t core_req,
  output logic      core_rsp_valid,
  input  logic      core_rsp_ready,
  output core_rsp_t core_rsp,
  output logic      down_req_valid,
  input  logic      down_req_ready,
  output down_req_t down_req,
  input  logic      down_rsp_valid,
  output logic      down_rsp_ready,
  input  down_rsp_t down_rsp
);

  // --------------------
  // internal wiring
  // --------------------
  logic [IDX_W-1:0]           rd_idx;
  line_entry_t [NUM_WAYS-1:0] rd_set;
  plru_t                      rd_plru;
  core_req_t                  req;
  lookup_t                    lookup;
  logic                       busy;
  logic                       respond;
  logic                       fill_done;
  logic                       buf_release;
  line_wr_t                   wr;
  logic                       promote;
  logic [IDX_W-1:0]           promote_idx;
  way_t                       promote_way;

  line_store u_store (
    .clk(clk), .rst_n(rst_n),
    .rd_idx(rd_idx), .rd_set(rd_set), .rd_plru(rd_plru),
    .wr(wr),
    .promote(promote), .promote_idx(promote_idx), .promote_way(promote_way)
  );

  req_decode u_decode (
    .clk(clk), .rst_n(rst_n),
    .core_req_valid(core_req_valid), .core_req_ready(core_req_ready), .core_req(core_req),
    .busy(busy), .buf_release(buf_release),
    .rd_idx(rd_idx), .rd_set(rd_set), .rd_plru(rd_plru),
    .req(req), .lookup(lookup)
  );

  miss_control u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .req(req), .lookup(lookup), .accepted(core_req_valid), .buf_release(buf_release),
    .down_req_valid(down_req_valid), .down_req_ready(down_req_ready), .down_req(down_req),
    .down_rsp_valid(down_rsp_valid), .down_rsp_ready(down_rsp_ready),
    .busy(busy), .respond(respond), .fill_done(fill_done)
  );

  resp_update u_result (
    .clk(clk), .rst_n(rst_n),
    .req(req), .lookup(lookup), .respond(respond), .fill_done(fill_done),
    .down_rsp(down_rsp),
    .core_rsp_valid(core_rsp_valid), .core_rsp_ready(core_rsp_ready), .core_rsp(core_rsp),
    .buf_release(buf_release), .wr(wr),
    .promote(promote), .promote_idx(promote_idx), .promote_way(promote_way)
  );

endmodule

`default_nettype wire

/* hw/line_store.sv */
`timescale 1ns/10ps
`default_nettype none

module line_store
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [IDX_W-1:0]           rd_idx,
  output line_entry_t [NUM_WAYS-1:0] rd_set,
  output plru_t                      rd_plru,
  input  line_wr_t                   wr,
  input  logic                       promote,
  input  logic [IDX_W-1:0]           promote_idx,
  input  way_t                       promote_way
);

  logic [STATE_W-1:0] state_q [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0]   tag_q   [NUM_SETS][NUM_WAYS];
  logic [LINE_W-1:0]  data_q  [NUM_SETS][NUM_WAYS];
  plru_t              plru_q  [NUM_SETS];

  // --------------------
  // read side
  // --------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_set[w].state = state_q[rd_idx][w];
      rd_set[w].tag   = tag_q[rd_idx][w];
      rd_set[w].data  = data_q[rd_idx][w];
    end
  end

  assign rd_plru = plru_q[rd_idx];

  // --------------------
  // state and tree update
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        plru_q[s] <= '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          state_q[s][w] <= INVALID;
        end
      end
    end else begin
      if (wr.en) begin
        state_q[wr.idx][wr.way] <= wr.entry.state;
      end
      // point the tree away from the promoted way
      if (promote) begin
        case (promote_way)
          2'd0: plru_q[promote_idx] <= {1'b1, 1'b1, plru_q[promote_idx][0]};
          2'd1: plru_q[promote_idx] <= {1'b1, 1'b0, plru_q[promote_idx][0]};
          2'd2: plru_q[promote_idx] <= {1'b0, plru_q[promote_idx][1], 1'b1};
          default: plru_q[promote_idx] <= {1'b0, plru_q[promote_idx][1], 1'b0};
        endcase
      end
    end
  end

  // tag only on allocation, data on every write
  always_ff @(posedge clk) begin
    if (wr.en) begin
      data_q[wr.idx][wr.way] <= wr.entry.data;
      if (wr.tag_wr) begin
        tag_q[wr.idx][wr.way] <= wr.entry.tag;
      end
    end
  end

  // a written line always ends in a legal valid state
  a_wr_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    wr.en |-> (wr.entry.state != INVALID) && (wr.entry.state <= MIGRATED));

endmodule

`default_nettype wire

/* hw/miss_control.sv */
`timescale 1ns/10ps
`default_nettype none

module miss_control
  import cache_msg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  core_req_t req,
  input  lookup_t   lookup,
  input  logic      accepted,
  input  logic      buf_release,
  output logic      down_req_valid,
  input  logic      down_req_ready,
  output down_req_t down_req,
  input  logic      down_rsp_valid,
  output logic      down_rsp_ready,
  output logic      busy,
  output logic      respond,
  output logic      fill_done
);

  typedef enum logic [2:0] {IDLE, ALLOCATE, ISSUE, WAIT_FILL, RESPOND} ctrl_e;

  ctrl_e    state_q;
  ctrl_e    state_nx;
  logic     busy_q;
  logic     no_issue;
  down_op_e op_nx;

  // hits that already own the line answer straight away
  assign no_issue = lookup.hit && ((req.op == RD) || (lookup.state == EXCLUSIVE) ||
                    (lookup.state == MODIFIED) || (lookup.state == MIGRATED));

  assign op_nx = lookup.hit ? DINV : ((req.op == RD) ? DRD : DRFO);

  always_comb begin
    state_nx = state_q;
    case (state_q)
      IDLE:      if (accepted && !busy_q) state_nx = ALLOCATE;
      ALLOCATE:  state_nx = no_issue ? RESPOND : ISSUE;
      ISSUE:     if (down_req_valid && down_req_ready) state_nx = WAIT_FILL;
      WAIT_FILL: if (fill_done) state_nx = RESPOND;
      RESPOND:   if (buf_release) state_nx = IDLE;
      default:   state_nx = IDLE;
    endcase
  end

  // busy comes out of reset high, so the core waits one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      busy_q  <= 1'b1;
    end else begin
      state_q <= state_nx;
      busy_q  <= (state_nx != IDLE);
    end
  end

  // --------------------
  // downstream request
  // --------------------
  always_ff @(posedge clk) begin
    if (state_q == ALLOCATE) begin
      down_req.op        <= op_nx;
      down_req.addr.flat <= req.addr.flat;
    end
  end

  assign down_req_valid = (state_q == ISSUE);
  assign down_rsp_ready = (state_q == WAIT_FILL);
  assign fill_done      = down_rsp_valid && down_rsp_ready;
  assign respond        = (state_q == RESPOND);
  assign busy           = busy_q;

  a_down_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    down_req_valid && !down_req_ready |=> down_req_valid && $stable(down_req));

endmodule

`default_nettype wire

/* hw/req_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module req_decode
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       core_req_valid,
  output logic                       core_req_ready,
  input  core_req_t                  core_req,
  input  logic                       busy,
  input  logic                       buf_release,
  output logic [IDX_W-1:0]           rd_idx,
  input  line_entry_t [NUM_WAYS-1:0] rd_set,
  input  plru_t                      rd_plru,
  output core_req_t                  req,
  output lookup_t                    lookup
);

  logic                held_q;
  logic                accept;
  logic [NUM_WAYS-1:0] hit_vec;
  logic [NUM_WAYS-1:0] inv_vec;
  way_t                hit_way;
  way_t                inv_way;
  way_t                victim_way;
  way_t                sel_way;

  // --------------------
  // request buffer
  // --------------------
  assign core_req_ready = !busy;
  assign accept         = core_req_valid && core_req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_q <= 1'b0;
    end else if (accept) begin
      held_q <= 1'b1;
    end else if (buf_release) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req <= core_req;
    end
  end

  // --------------------
  // lookup
  // --------------------
  assign rd_idx = req.addr.split.idx;

  // walk down so the lowest matching way wins
  always_comb begin
    hit_way = '0;
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      inv_vec[w] = (rd_set[w].state == INVALID);
      hit_vec[w] = held_q && !inv_vec[w] && (rd_set[w].tag == req.addr.split.tag);
      if (hit_vec[w]) hit_way = way_t'(w);
      if (inv_vec[w]) inv_way = way_t'(w);
    end
  end

  assign victim_way = {rd_plru[2], rd_plru[2] ? rd_plru[0] : rd_plru[1]};
  assign sel_way    = (|hit_vec) ? hit_way : ((|inv_vec) ? inv_way : victim_way);

  assign lookup.hit   = |hit_vec;
  assign lookup.way   = sel_way;
  assign lookup.idx   = rd_idx;
  assign lookup.state = coh_state_e'(rd_set[sel_way].state);
  assign lookup.data  = rd_set[sel_way].data;

  a_single_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_vec));

endmodule

`default_nettype wire

/* hw/resp_update.sv */
`timescale 1ns/10ps
`default_nettype none

module resp_update
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  core_req_t         req,
  input  lookup_t           lookup,
  input  logic              respond,
  input  logic              fill_done,
  input  down_rsp_t         down_rsp,
  output logic              core_rsp_valid,
  input  logic              core_rsp_ready,
  output core_rsp_t         core_rsp,
  output logic              buf_release,
  output line_wr_t          wr,
  output logic              promote,
  output logic [IDX_W-1:0]  promote_idx,
  output way_t              promote_way
);

  logic              filled_q;
  fill_rsp_e         fill_rsp_q;
  logic [LINE_W-1:0] fill_data_q;
  coh_state_e        state_nx;
  logic [LINE_W-1:0] data_nx;
  logic              load;

  assign buf_release = core_rsp_valid && core_rsp_ready;
  assign load        = respond && !core_rsp_valid;

  // --------------------
  // fill capture
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      filled_q <= 1'b0;
    end else if (fill_done) begin
      filled_q <= (down_rsp.rsp != ACK);
    end else if (buf_release) begin
      filled_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_done) begin
      fill_rsp_q  <= down_rsp.rsp;
      fill_data_q <= down_rsp.data;
    end
  end

  // new line contents
  always_comb begin
    data_nx  = filled_q ? fill_data_q : lookup.data;
    state_nx = lookup.state;
    case (req.op)
      RD: begin
        if (filled_q) state_nx = (fill_rsp_q == SNOOP) ? SHARED : EXCLUSIVE;
      end
      WR: begin
        state_nx = MODIFIED;
        data_nx  = req.data;
      end
      RFO:     state_nx = MIGRATED;
      default: state_nx = lookup.state;
    endcase
  end

  // --------------------
  // core response
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rsp_valid <= 1'b0;
    end else if (load) begin
      core_rsp_valid <= 1'b1;
    end else if (buf_release) begin
      core_rsp_valid <= 1'b0;
    end
  end

  // writes answer with zero
  always_ff @(posedge clk) begin
    if (load) begin
      core_rsp.data <= (req.op == WR) ? '0 : data_nx;
    end
  end

  // line write lands with the response transfer
  assign wr.en          = buf_release;
  assign wr.idx         = lookup.idx;
  assign wr.way         = lookup.way;
  assign wr.entry.state = state_nx;
  assign wr.entry.tag   = req.addr.split.tag;
  assign wr.entry.data  = data_nx;
  assign wr.tag_wr      = !lookup.hit;

  assign promote     = buf_release && lookup.hit;
  assign promote_idx = lookup.idx;
  assign promote_way = lookup.way;

endmodule

`default_nettype wire

/* tests/coh_cache_tb_tasks.svh */
`ifndef COH_CACHE_TB_TASKS_SVH
`define COH_CACHE_TB_TASKS_SVH

localparam int WAIT_LIMIT = 200;

// --------------------
// handshake waits
// --------------------
task automatic wait_req_ready();
  int n;
  n = 0;
  @(negedge clk);
  while (!core_req_ready) begin
    n++;
    if (n > WAIT_LIMIT) fail_stop("core request was never accepted");
    @(negedge clk);
  end
endtask

task automatic wait_rsp_valid();
  int n;
  n = 0;
  @(negedge clk);
  while (!core_rsp_valid) begin
    n++;
    if (n > WAIT_LIMIT) fail_stop("core response never became valid");
    @(negedge clk);
  end
endtask

task automatic wait_rsp_done();
  int n;
  n = 0;
  @(negedge clk);
  while (!(core_rsp_valid && core_rsp_ready)) begin
    n++;
    if (n > WAIT_LIMIT) fail_stop("core response never completed");
    @(negedge clk);
  end
  // transfer happens on this edge
  @(posedge clk);
endtask

// one core request, fill data chosen up front
task automatic access(input string name, input core_op_e op, input logic [ADDR_W-1:0] a,
                      input logic [LINE_W-1:0] d, input int stall);
  test_name = name;
  next_fill = rand_word();
  model_access(op, a, d);
  @(posedge clk);
  core_req_valid     <= 1'b1;
  core_req.op        <= op;
  core_req.addr.flat <= a;
  core_req.data      <= d;
  if (stall > 0) core_rsp_ready <= 1'b0;
  wait_req_ready();
  @(posedge clk);
  core_req_valid <= 1'b0;
  if (stall > 0) begin
    wait_rsp_valid();
    repeat (stall) @(posedge clk);
    core_rsp_ready <= 1'b1;
  end
  wait_rsp_done();
endtask

`endif

/* tests/coh_cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module coh_cache_tb
  import cache_geom_pkg::*;
  import cache_msg_pkg::*;
();

  logic              clk;
  logic              rst_n;
  logic              core_req_valid;
  logic              core_req_ready;
  core_req_t         core_req;
  logic              core_rsp_valid;
  logic              core_rsp_ready;
  core_rsp_t         core_rsp;
  logic              down_req_valid;
  logic              down_req_ready;
  down_req_t         down_req;
  logic              down_rsp_valid;
  logic              down_rsp_ready;
  down_rsp_t         down_rsp;

  // reference model of the array
  logic [2:0]        m_state [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
  logic [LINE_W-1:0] m_data  [NUM_SETS][NUM_WAYS];
  plru_t             m_plru  [NUM_SETS];

  logic              exp_issue;
  down_op_e          exp_op;
  logic [ADDR_W-1:0] exp_addr;
  logic [LINE_W-1:0] exp_rsp;
  fill_rsp_e         fill_mode;
  logic [LINE_W-1:0] next_fill;
  logic              issued;
  logic [TAG_W-1:0]  evicted_tag;
  string             test_name;
  integer            seed;

  coh_cache_top uut (
    .clk(clk), .rst_n(rst_n),
    .core_req_valid(core_req_valid), .core_req_ready(core_req_ready), .core_req(core_req),
    .core_rsp_valid(core_rsp_valid), .core_rsp_ready(core_rsp_ready), .core_rsp(core_rsp),
    .down_req_valid(down_req_valid), .down_req_ready(down_req_ready), .down_req(down_req),
    .down_rsp_valid(down_rsp_valid), .down_rsp_ready(down_rsp_ready), .down_rsp(down_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // --------------------
  // reference model
  // --------------------
  task automatic model_access(input core_op_e op, input logic [ADDR_W-1:0] a,
                              input logic [LINE_W-1:0] d);
    blk_addr_u         ba;
    logic [IDX_W-1:0]  s;
    way_t              v;
    logic              hit;
    logic              found;
    logic [2:0]        st;
    logic [LINE_W-1:0] dat;
    ba.flat = a;
    s       = ba.split.idx;
    hit     = 1'b0;
    found   = 1'b0;
    v       = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (m_state[s][w] != INVALID && m_tag[s][w] == ba.split.tag) begin
        hit = 1'b1;
        v   = way_t'(w);
      end
    end
    // lowest free way, then the tree victim
    if (!hit) begin
      for (int w = NUM_WAYS - 1; w >= 0; w--) begin
        if (m_state[s][w] == INVALID) begin
          found = 1'b1;
          v     = way_t'(w);
        end
      end
      if (!found) v = {m_plru[s][2], m_plru[s][2] ? m_plru[s][0] : m_plru[s][1]};
    end
    evicted_tag = m_tag[s][v];
    exp_issue   = !hit || (op != RD && m_state[s][v] == SHARED);
    exp_op      = hit ? DINV : ((op == RD) ? DRD : DRFO);
    exp_addr    = a;
    st          = m_state[s][v];
    dat         = hit ? m_data[s][v] : next_fill;
    case (op)
      RD:      if (!hit) st = (fill_mode == SNOOP) ? SHARED : EXCLUSIVE;
      WR:      st = MODIFIED;
      default: st = MIGRATED;
    endcase
    if (op == WR) dat = d;
    exp_rsp = (op == WR) ? '0 : dat;
    m_state[s][v] = st;
    m_data[s][v]  = dat;
    if (!hit) m_tag[s][v] = ba.split.tag;
    if (hit) begin
      case (v)
        2'd0:    m_plru[s] = {1'b1, 1'b1, m_plru[s][0]};
        2'd1:    m_plru[s] = {1'b1, 1'b0, m_plru[s][0]};
        2'd2:    m_plru[s] = {1'b0, m_plru[s][1], 1'b1};
        default: m_plru[s] = {1'b0, m_plru[s][1], 1'b0};
      endcase
    end
  endtask

  // --------------------
  // downstream responder
  // --------------------
  always @(posedge clk) begin
    if (core_req_valid && core_req_ready) begin
      issued <= 1'b0;
    end else if (down_req_valid && down_req_ready) begin
      issued         <= 1'b1;
      down_rsp_valid <= 1'b1;
      down_rsp.rsp   <= (down_req.op == DINV) ? ACK : fill_mode;
      down_rsp.data  <= next_fill;
    end else if (down_rsp_valid && down_rsp_ready) begin
      down_rsp_valid <= 1'b0;
    end
  end

  // --------------------
  // checks
  // --------------------
  a_down_expected: assert property (@(posedge clk) disable iff (!rst_n)
    down_req_valid |-> exp_issue)
    else fail_stop($sformatf("MISMATCH %s: expected no down_req, actual op %0d",
                             test_name, down_req.op));

  a_down_op: assert property (@(posedge clk) disable iff (!rst_n)
    down_req_valid |-> down_req.op == exp_op)
    else fail_stop($sformatf("MISMATCH %s: expected op %0d, actual %0d",
                             test_name, exp_op, down_req.op));

  a_down_addr: assert property (@(posedge clk) disable iff (!rst_n)
    down_req_valid |-> down_req.addr.flat == exp_addr)
    else fail_stop($sformatf("MISMATCH %s: expected addr %h, actual %h",
                             test_name, exp_addr, down_req.addr.flat));

  a_fill_ready: assert property (@(posedge clk) disable iff (!rst_n)
    down_rsp_ready |-> down_rsp_valid)
    else fail_stop("down response ready was high with no fill pending");

  a_issued: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid && core_rsp_ready |-> issued == exp_issue)
    else fail_stop($sformatf("MISMATCH %s: expected down transfers %0d, actual %0d",
                             test_name, exp_issue, issued));

  a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid |-> core_rsp.data == exp_rsp)
    else fail_stop($sformatf("MISMATCH %s: expected data %h, actual %h",
                             test_name, exp_rsp, core_rsp.data));

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp.data))
    else fail_stop("core response dropped or changed while ready was low");

  a_req_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid |-> !core_req_ready)
    else fail_stop("core request ready went high before the response transfer");

  // --------------------
  // stimulus
  // --------------------
  initial begin
    logic [ADDR_W-1:0] addr_a;
    logic [ADDR_W-1:0] addr_b;
    logic [ADDR_W-1:0] addr_c;
    logic [TAG_W-1:0]  base;
    logic [IDX_W-1:0]  set_i;
    logic [31:0]       r;
    seed           = 32'h95ee;
    rst_n          = 1'b0;
    core_req_valid = 1'b0;
    core_req       = '0;
    core_rsp_ready = 1'b0;
    down_req_ready = 1'b0;
    down_rsp_valid = 1'b0;
    down_rsp       = '0;
    issued         = 1'b0;
    exp_issue      = 1'b0;
    exp_op         = DRD;
    exp_addr       = '0;
    exp_rsp        = '0;
    fill_mode      = FETCH;
    next_fill      = '0;
    test_name      = "reset";
    for (int s = 0; s < NUM_SETS; s++) begin
      m_plru[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_state[s][w] = INVALID;
        m_tag[s][w]   = '0;
        m_data[s][w]  = '0;
      end
    end
    repeat (4) @(posedge clk);
    rst_n          <= 1'b1;
    core_rsp_ready <= 1'b1;
    down_req_ready <= 1'b1;
    r      = rand_word();
    addr_a = r[ADDR_W-1:0];
    addr_b = {addr_a[ADDR_W-1:IDX_W] ^ 12'h001, addr_a[IDX_W-1:0]};
    addr_c = {addr_a[ADDR_W-1:IDX_W] ^ 12'h002, addr_a[IDX_W-1:0] + 4'd3};

    access("read_miss", RD, addr_a, rand_word(), 0);
    access("read_hit", RD, addr_a, rand_word(), 0);
    access("write_exclusive", WR, addr_a, rand_word(), 0);
    fill_mode = SNOOP;
    access("read_shared", RD, addr_b, rand_word(), 0);
    access("write_shared", WR, addr_b, rand_word(), 0);
    access("read_after_write", RD, addr_b, rand_word(), 0);
    fill_mode = FETCH;
    access("rfo_miss", RFO, addr_c, rand_word(), 0);

    // one set, five tags
    r     = rand_word();
    base  = r[TAG_W-1:0];
    set_i = addr_a[IDX_W-1:0] + 4'd1;
    for (int i = 0; i < 4; i++) begin
      access("set_fill", RD, {base + TAG_W'(i), set_i}, rand_word(), 0);
    end
    access("set_touch", RD, {base, set_i}, rand_word(), 0);
    access("set_touch", RD, {base + 12'd2, set_i}, rand_word(), 0);
    access("set_evict", RD, {base + 12'd4, set_i}, rand_word(), 0);
    access("victim_reread", RD, {evicted_tag, set_i}, rand_word(), 0);
    access("survivor_read", RD, {base, set_i}, rand_word(), 0);

    access("rsp_backpressure", RD, addr_a, rand_word(), 4);
    access("rsp_backpressure", RFO, addr_c, rand_word(), 3);

    $display("STATUS: PASS");
    $finish;
  end

`include "coh_cache_tb_tasks.svh"

endmodule

`default_nettype wire
